/* Makefile */
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_mem_access -Mdir obj_dir -f filelist.f

run: compile
	-./obj_dir/Vtb_mem_access > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then exit 1; fi
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* filelist.f */
+incdir+.
mem_pkg.sv
mem_addr_xlate.sv
mem_exc_detect.sv
mem_llsc_monitor.sv
mem_byte_align.sv
mem_access_stage.sv
mem_access_properties.sv
tb_mem_access.sv

/* mem_access_properties.sv */
`timescale 1ns/100ps
`include "mem_defines.svh"

module mem_access_properties (
    input logic clk, rst_n, req_valid, busy, interrupt, exc_valid, done, sc_result,
    input logic cyc, stb, we, tga_cached, ack,
    input mem_pkg::stage_state_t state,
    input mem_pkg::mem_req_t req_q,
    input mem_pkg::tlb_result_t tlb_q,
    input logic [2:0] config_k0,
    input mem_pkg::exc_info_t exc,
    input mem_pkg::word_t rdata, dat_o, dat_i,
    input mem_pkg::rstrb_t rstrb,
    input mem_pkg::strb_t sel,
    input mem_pkg::paddr_t adr
);

    int unsigned fail_count = 0;
    logic link;
    mem_pkg::vaddr_t link_addr;
    logic [1:0] off;
    logic mapped, misalign, ade, tlb_hit, exp_exc, link_ok, decide;
    mem_pkg::paddr_t exp_adr;
    mem_pkg::exc_code_t exp_code;
    logic [35:0] exp_st;    // {sel, data}
    mem_pkg::rstrb_t exp_rstrb;

    function automatic logic [31:0] lane_mask(input logic [3:0] s);
        return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    function automatic logic [35:0] store_lanes(input logic [3:0] op, input logic [1:0] o,
                                                input logic [31:0] rt);
        case (op)
            `MEM_OP_SB:  return {4'b0001 << o, {4{rt[7:0]}}};
            `MEM_OP_SH:  return {o[1] ? 4'b1100 : 4'b0011, {2{rt[15:0]}}};
            `MEM_OP_SWL: return {4'b1111 >> (2'd3 - o), rt >> (8 * (3 - o))};
            `MEM_OP_SWR: return {4'b1111 << o, rt << (8 * o)};
            default:     return {4'b1111, rt};
        endcase
    endfunction

    assign off     = req_q.vaddr[1:0];
    assign decide  = (state == mem_pkg::DECIDE);
    assign mapped  = (req_q.vaddr[31:30] != 2'b10);
    assign exp_adr = mapped ? {tlb_q.pfn, req_q.vaddr[11:0]} : {3'b000, req_q.vaddr[28:0]};
    assign misalign = ((req_q.op inside {`MEM_OP_SH, `MEM_OP_LH, `MEM_OP_LHU}) && off[0])
                   || ((req_q.op inside {`MEM_OP_SW, `MEM_OP_LW}) && off != 2'b00);
    assign ade     = misalign && (req_q.is_load || req_q.is_store);
    assign tlb_hit = tlb_q.found && tlb_q.v;
    assign exp_exc = interrupt || req_q.prior_exc || ade
                  || (mapped && (!tlb_hit || (req_q.is_store && !tlb_q.d)));
    assign exp_code = interrupt ? `MEM_EXC_INT : req_q.prior_exc ? req_q.prior_code
                    : ade ? (req_q.is_store ? `MEM_EXC_ADES : `MEM_EXC_ADEL)
                    : tlb_hit ? `MEM_EXC_MOD : (req_q.is_store ? `MEM_EXC_TLBS : `MEM_EXC_TLBL);
    assign exp_st  = store_lanes(req_q.op, off, req_q.wdata);
    assign link_ok = link && (link_addr == req_q.vaddr);

    always_comb begin
        case (req_q.op)
            `MEM_OP_LBU: exp_rstrb = {3'b000, off};
            `MEM_OP_LB:  exp_rstrb = {3'b010, off};
            `MEM_OP_LHU: exp_rstrb = {3'b001, off[1], 1'b0};
            `MEM_OP_LH:  exp_rstrb = {3'b011, off[1], 1'b0};
            `MEM_OP_LWL: exp_rstrb = {1'b1, 4'b1111 << (2'd3 - off)};
            `MEM_OP_LWR: exp_rstrb = {1'b1, 4'b1111 >> off};
            default:     exp_rstrb = 5'b11111;
        endcase
    end

    // reference link model
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            link <= 1'b0;
        end else if (decide && exp_exc) begin
            link <= 1'b0;
        end else if (decide && req_q.is_ll) begin
            link      <= 1'b1;
            link_addr <= req_q.vaddr;
        end
    end

    a_xlate: assert property (@(posedge clk) disable iff (!rst_n)
        cyc |-> adr == exp_adr && tga_cached ==
        ((req_q.vaddr[31:29] == `MEM_KSEG0_PREFIX && config_k0 == `MEM_ATTR_CACHED)
         || (mapped && tlb_q.c == `MEM_ATTR_CACHED)))
    else begin
        fail_count++;
        $error("bus address or cached tag wrong");
    end
    a_store: assert property (@(posedge clk) disable iff (!rst_n)
        cyc && we |-> sel == exp_st[35:32]
        && (dat_o & lane_mask(sel)) == (exp_st[31:0] & lane_mask(sel)))
    else begin
        fail_count++;
        $error("store strobes or data wrong");
    end
    a_exc_when: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !busy |=> exc_valid == exp_exc)
    else begin
        fail_count++;
        $error("exception flag wrong after accept");
    end
    a_exc_info: assert property (@(posedge clk) disable iff (!rst_n)
        exc_valid |-> exc.code == exp_code
        && exc.badvaddr == (interrupt ? 32'h0 : req_q.vaddr)
        && exc.tlb_refill == (!interrupt && !req_q.prior_exc && !ade && mapped && !tlb_q.found))
    else begin
        fail_count++;
        $error("exception code or badvaddr wrong");
    end
    a_exc_nobus: assert property (@(posedge clk) disable iff (!rst_n)
        exc_valid |=> !exc_valid && !cyc)
    else begin
        fail_count++;
        $error("bus cycle after exception");
    end
    a_sc_ok: assert property (@(posedge clk) disable iff (!rst_n)
        decide && req_q.is_sc && !exp_exc && link_ok |=> cyc && we)
    else begin
        fail_count++;
        $error("linked SC did not write");
    end
    a_sc_fail: assert property (@(posedge clk) disable iff (!rst_n)
        decide && req_q.is_sc && !exp_exc && !link_ok |-> (done && !sc_result) ##1 !cyc)
    else begin
        fail_count++;
        $error("unlinked SC not retired in DECIDE");
    end
    a_stable: assert property (@(posedge clk) disable iff (!rst_n)
        cyc && !ack |=> cyc && stb && $stable(adr) && $stable(sel)
        && $stable(dat_o) && $stable(we))
    else begin
        fail_count++;
        $error("bus signals moved before ack");
    end
    a_done: assert property (@(posedge clk) disable iff (!rst_n)
        cyc && ack |=> done && !cyc && rdata == $past(dat_i) && sc_result == req_q.is_sc)
    else begin
        fail_count++;
        $error("done, rdata or sc_result wrong after ack");
    end
    a_rstrb: assert property (@(posedge clk) disable iff (!rst_n)
        done && req_q.is_load |-> rstrb == exp_rstrb)
    else begin
        fail_count++;
        $error("load extract code wrong");
    end
    a_busy: assert property (@(posedge clk) disable iff (!rst_n)
        cyc |-> stb && busy)
    else begin
        fail_count++;
        $error("busy or stb low during bus cycle");
    end

endmodule

bind mem_access_stage mem_access_properties props (
    .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .busy(busy), .interrupt(interrupt),
    .exc_valid(exc_valid), .done(done), .sc_result(sc_result), .cyc(cyc), .stb(stb),
    .we(we), .tga_cached(tga_cached), .ack(ack), .state(state), .req_q(req_q),
    .tlb_q(tlb_q), .config_k0(config_k0), .exc(exc), .rdata(rdata), .dat_o(dat_o),
    .dat_i(dat_i), .rstrb(rstrb), .sel(sel), .adr(adr)
);

/* mem_access_stage.sv */
`timescale 1ns/100ps

module mem_access_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  mem_pkg::mem_req_t    req,
    input  mem_pkg::tlb_result_t tlb,
    input  logic [2:0]           config_k0,
    input  logic                 interrupt,
    output logic                 busy,
    output logic                 exc_valid,
    output mem_pkg::exc_info_t   exc,
    output logic                 done,
    output mem_pkg::word_t       rdata,
    output mem_pkg::rstrb_t      rstrb,
    output logic                 sc_result,
    output logic                 cyc,
    output logic                 stb,
    output logic                 we,
    output mem_pkg::strb_t       sel,
    output mem_pkg::paddr_t      adr,
    output mem_pkg::word_t       dat_o,
    output logic                 tga_cached,
    input  mem_pkg::word_t       dat_i,
    input  logic                 ack
);

    mem_pkg::stage_state_t state;
    mem_pkg::mem_req_t     req_q;
    mem_pkg::tlb_result_t  tlb_q;

    logic            mapped;
    logic            cached;
    mem_pkg::paddr_t paddr;
    logic            exc_valid_comb;
    logic            sc_ok;
    logic            ll_set;
    logic            link_clear;
    logic            in_decide;
    logic            sc_fail;
    mem_pkg::strb_t  wstrb;
    mem_pkg::word_t  wdata;

    assign busy      = (state != mem_pkg::IDLE);
    assign in_decide = (state == mem_pkg::DECIDE);

    // request and tlb captured on acceptance
    always_ff @(posedge clk) begin
        if (req_valid && !busy) begin
            req_q <= req;
            tlb_q <= tlb;
        end
    end

    mem_addr_xlate u_xlate (
        .vaddr     (req_q.vaddr),
        .tlb       (tlb_q),
        .config_k0 (config_k0),
        .mapped    (mapped),
        .paddr     (paddr),
        .cached    (cached)
    );

    mem_exc_detect u_exc (
        .req            (req_q),
        .tlb            (tlb_q),
        .mapped         (mapped),
        .interrupt      (interrupt),
        .exc_valid_comb (exc_valid_comb),
        .exc            (exc)
    );

    assign ll_set     = in_decide && !exc_valid_comb && req_q.is_ll;
    assign link_clear = in_decide && exc_valid_comb;

    mem_llsc_monitor u_llsc (
        .clk    (clk),
        .rst_n  (rst_n),
        .ll_set (ll_set),
        .clear  (link_clear),
        .vaddr  (req_q.vaddr),
        .is_sc  (req_q.is_sc),
        .sc_ok  (sc_ok)
    );

    mem_byte_align u_align (
        .op      (req_q.op),
        .addr_lo (paddr[1:0]),
        .rt      (req_q.wdata),
        .wstrb   (wstrb),
        .wdata   (wdata),
        .rstrb   (rstrb)
    );

    // failed SC retires in DECIDE without touching the bus
    assign sc_fail = req_q.is_sc && !sc_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= mem_pkg::IDLE;
        end else begin
            case (state)
                mem_pkg::IDLE: begin
                    if (req_valid) begin
                        state <= mem_pkg::DECIDE;
                    end
                end
                mem_pkg::DECIDE: begin
                    if (exc_valid_comb || sc_fail) begin
                        state <= mem_pkg::IDLE;
                    end else begin
                        state <= mem_pkg::BUS;
                    end
                end
                mem_pkg::BUS: begin
                    if (ack) begin
                        state <= mem_pkg::RESP;
                    end
                end
                default: state <= mem_pkg::IDLE;    // RESP lasts one cycle
            endcase
        end
    end

    // bus payload latched once so config_k0 changes cannot move it mid-cycle
    always_ff @(posedge clk) begin
        if (in_decide) begin
            adr        <= paddr;
            we         <= req_q.is_store;
            sel        <= req_q.is_store ? wstrb : 4'b1111;
            dat_o      <= wdata;
            tga_cached <= cached;
        end
    end

    always_ff @(posedge clk) begin
        if (state == mem_pkg::BUS && ack) begin
            rdata <= dat_i;
        end
    end

    assign cyc = (state == mem_pkg::BUS);
    assign stb = cyc;

    assign exc_valid = in_decide && exc_valid_comb;
    assign done      = (state == mem_pkg::RESP) || (in_decide && !exc_valid_comb && sc_fail);
    assign sc_result = (state == mem_pkg::RESP) && req_q.is_sc;    // only a linked SC gets here

endmodule

/* mem_addr_xlate.sv */
`timescale 1ns/100ps
`include "mem_defines.svh"

module mem_addr_xlate (
    input  mem_pkg::vaddr_t      vaddr,
    input  mem_pkg::tlb_result_t tlb,
    input  logic [2:0]           config_k0,
    output logic                 mapped,
    output mem_pkg::paddr_t      paddr,
    output logic                 cached
);

    logic kseg0;
    logic kseg1;
    logic kseg0_cached;
    logic tlb_cached;

    assign kseg0 = (vaddr[31:29] == `MEM_KSEG0_PREFIX);
    assign kseg1 = (vaddr[31:29] == `MEM_KSEG1_PREFIX);

    // useg and kseg2/3 go through the TLB
    assign mapped = !(kseg0 || kseg1);

    always_comb begin
        if (mapped) begin
            paddr = {tlb.pfn, vaddr[11:0]};
        end else begin
            paddr = {3'b000, vaddr[28:0]};    // strip segment bits
        end
    end

    assign kseg0_cached = kseg0 && (config_k0 == `MEM_ATTR_CACHED);
    assign tlb_cached   = mapped && (tlb.c == `MEM_ATTR_CACHED);

    // kseg1 falls through both terms
    assign cached = kseg0_cached || tlb_cached;

endmodule

/* mem_byte_align.sv */
`timescale 1ns/100ps
`include "mem_defines.svh"

module mem_byte_align (
    input  mem_pkg::mem_op_t op,
    input  logic [1:0]       addr_lo,
    input  mem_pkg::word_t   rt,
    output mem_pkg::strb_t   wstrb,
    output mem_pkg::word_t   wdata,
    output mem_pkg::rstrb_t  rstrb
);

    // store lanes and data
    always_comb begin
        wstrb = 4'b1111;    // SW, SC
        wdata = rt;
        case (op)
            `MEM_OP_SB: begin
                wstrb = 4'b0001 << addr_lo;
                wdata = {4{rt[7:0]}};
            end
            `MEM_OP_SH: begin
                wstrb = addr_lo[1] ? 4'b1100 : 4'b0011;
                wdata = {2{rt[15:0]}};
            end
            `MEM_OP_SWL: begin
                // high bytes of rt land from the offset downward
                case (addr_lo)
                    2'b00:   wstrb = 4'b0001;
                    2'b01:   wstrb = 4'b0011;
                    2'b10:   wstrb = 4'b0111;
                    default: wstrb = 4'b1111;
                endcase
                wdata = rt >> (5'd8 * (5'd3 - {3'b000, addr_lo}));
            end
            `MEM_OP_SWR: begin
                case (addr_lo)
                    2'b00:   wstrb = 4'b1111;
                    2'b01:   wstrb = 4'b1110;
                    2'b10:   wstrb = 4'b1100;
                    default: wstrb = 4'b1000;
                endcase
                wdata = rt << (5'd8 * {3'b000, addr_lo});
            end
            default: ;
        endcase
    end

    // load extract: [4] word merge, [3] sign, [2] half, [1:0] lane
    always_comb begin
        rstrb = 5'b11111;    // LW, LL
        case (op)
            `MEM_OP_LBU: rstrb = {3'b000, addr_lo};
            `MEM_OP_LB:  rstrb = {3'b010, addr_lo};
            `MEM_OP_LHU: rstrb = {3'b001, addr_lo[1], 1'b0};
            `MEM_OP_LH:  rstrb = {3'b011, addr_lo[1], 1'b0};
            `MEM_OP_LWL: begin
                case (addr_lo)
                    2'b00:   rstrb = 5'b11000;
                    2'b01:   rstrb = 5'b11100;
                    2'b10:   rstrb = 5'b11110;
                    default: rstrb = 5'b11111;
                endcase
            end
            `MEM_OP_LWR: begin
                case (addr_lo)
                    2'b00:   rstrb = 5'b11111;
                    2'b01:   rstrb = 5'b10111;
                    2'b10:   rstrb = 5'b10011;
                    default: rstrb = 5'b10001;
                endcase
            end
            default: ;
        endcase
    end

endmodule

/* mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// cause codes
`define MEM_EXC_INT         5'd0
`define MEM_EXC_MOD         5'd1
`define MEM_EXC_TLBL        5'd2
`define MEM_EXC_TLBS        5'd3
`define MEM_EXC_ADEL        5'd4
`define MEM_EXC_ADES        5'd5

// memory operation codes, LL rides on LW and SC on SW
`define MEM_OP_SB           4'd0
`define MEM_OP_SH           4'd1
`define MEM_OP_SW           4'd2
`define MEM_OP_SWL          4'd3
`define MEM_OP_SWR          4'd4
`define MEM_OP_LBU          4'd5
`define MEM_OP_LB           4'd6
`define MEM_OP_LHU          4'd7
`define MEM_OP_LH           4'd8
`define MEM_OP_LWL          4'd9
`define MEM_OP_LWR          4'd10
`define MEM_OP_LW           4'd11

`define MEM_KSEG0_PREFIX    3'b100    // unmapped, cacheability from config_k0
`define MEM_KSEG1_PREFIX    3'b101    // unmapped, always uncached
`define MEM_ATTR_CACHED     3'd3

`endif

/* mem_exc_detect.sv */
`timescale 1ns/100ps
`include "mem_defines.svh"

module mem_exc_detect (
    input  mem_pkg::mem_req_t    req,
    input  mem_pkg::tlb_result_t tlb,
    input  logic                 mapped,
    input  logic                 interrupt,
    output logic                 exc_valid_comb,
    output mem_pkg::exc_info_t   exc
);

    logic half_op;
    logic word_op;
    logic ades;
    logic adel;
    logic tlb_refill;
    logic tlb_invalid;
    logic tlb_mod;
    logic tlb_exc;
    logic odd_addr;
    logic unaligned_word;

    assign odd_addr       = req.vaddr[0];
    assign unaligned_word = (req.vaddr[1:0] != 2'b00);

    assign half_op = (req.op == `MEM_OP_SH) || (req.op == `MEM_OP_LH) || (req.op == `MEM_OP_LHU);
    assign word_op = (req.op == `MEM_OP_SW) || (req.op == `MEM_OP_LW);  // SC and LL included

    assign ades = req.is_store && ((half_op && odd_addr) || (word_op && unaligned_word));
    assign adel = req.is_load && ((half_op && odd_addr) || (word_op && unaligned_word));

    // only mapped accesses consult the TLB
    assign tlb_refill  = mapped && !tlb.found;
    assign tlb_invalid = mapped && tlb.found && !tlb.v;
    assign tlb_mod     = mapped && req.is_store && tlb.found && tlb.v && !tlb.d;
    assign tlb_exc     = tlb_refill || tlb_invalid || tlb_mod;

    assign exc_valid_comb = interrupt || req.prior_exc || ades || adel || tlb_exc;

    always_comb begin
        exc.code       = `MEM_EXC_INT;
        exc.badvaddr   = req.vaddr;
        exc.tlb_refill = 1'b0;
        if (interrupt) begin
            exc.badvaddr = '0;    // no address for an interrupt
        end else if (req.prior_exc) begin
            exc.code = req.prior_code;
        end else if (ades) begin
            exc.code = `MEM_EXC_ADES;
        end else if (adel) begin
            exc.code = `MEM_EXC_ADEL;
        end else if (tlb_mod) begin
            exc.code = `MEM_EXC_MOD;
        end else if (tlb_exc) begin
            // refill and invalid share the code, refill picks the vector
            exc.code       = req.is_store ? `MEM_EXC_TLBS : `MEM_EXC_TLBL;
            exc.tlb_refill = tlb_refill;
        end
    end

endmodule

/* mem_llsc_monitor.sv */
`timescale 1ns/100ps

module mem_llsc_monitor (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ll_set,
    input  logic            clear,
    input  mem_pkg::vaddr_t vaddr,
    input  logic            is_sc,
    output logic            sc_ok
);

    logic            link_bit;
    mem_pkg::vaddr_t link_addr;

    // any exception breaks the link
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            link_bit <= 1'b0;
        end else if (ll_set) begin
            link_bit <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ll_set) begin
            link_addr <= vaddr;
        end
    end

    assign sc_ok = is_sc && link_bit && (link_addr == vaddr);

endmodule

/* mem_pkg.sv */
package mem_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [31:0] word_t;
    typedef logic [19:0] pfn_t;
    typedef logic [3:0]  strb_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [3:0]  mem_op_t;
    typedef logic [4:0]  rstrb_t;

    // one load or store as it leaves EX
    typedef struct packed {
        vaddr_t    vaddr;
        mem_op_t   op;
        word_t     wdata;        // rt register
        logic      is_load;
        logic      is_store;
        logic      is_ll;
        logic      is_sc;
        logic      prior_exc;    // raised further up the pipe
        exc_code_t prior_code;
    } mem_req_t;

    typedef struct packed {
        logic       found;
        logic       v;
        logic       d;
        logic [2:0] c;           // cache attribute
        pfn_t       pfn;
    } tlb_result_t;

    typedef struct packed {
        exc_code_t code;
        vaddr_t    badvaddr;
        logic      tlb_refill;
    } exc_info_t;

    typedef enum logic [1:0] {IDLE, DECIDE, BUS, RESP} stage_state_t;

endpackage

/* tb_mem_access.sv */
`timescale 1ns/100ps
`include "mem_defines.svh"

module tb_mem_access;

    localparam int NUM_RAND = 400;
    localparam int MEM_WORDS = 64;
    localparam int WORST_CYCLES = 16;    // wait, decide, 4 bus, resp, margin

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic req_valid = 1'b0;
    logic interrupt = 1'b0;
    logic ack = 1'b0;
    logic [2:0] config_k0 = 3'd0;
    mem_pkg::mem_req_t req = '0;
    mem_pkg::tlb_result_t tlb = '0;
    mem_pkg::word_t dat_i = '0;
    logic busy, exc_valid, done, sc_result, cyc, stb, we, tga_cached;
    mem_pkg::exc_info_t exc;
    mem_pkg::word_t rdata, dat_o;
    mem_pkg::rstrb_t rstrb;
    mem_pkg::strb_t sel;
    mem_pkg::paddr_t adr;

    logic [31:0] lfsr = 32'ha683;
    logic [1:0] ack_delay = 2'd0;
    logic [1:0] wait_cnt;
    mem_pkg::word_t mem [MEM_WORDS];
    mem_pkg::tlb_result_t tlb_clean = '{found: 1'b1, v: 1'b1, d: 1'b1, c: 3'd2, pfn: 20'h00123};

    mem_access_stage dut (.*);

    initial forever #20 clk = ~clk;

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic mem_pkg::mem_req_t rand_req();
        mem_pkg::mem_req_t r;
        logic [2:0] seg [4] = '{3'b000, 3'b100, 3'b101, 3'b110};    // useg, k0, k1, k2
        r.op = 4'(next_bits(4) % 12);
        r.vaddr = {seg[next_bits(2)], 21'(next_bits(21)), 6'(next_bits(6)), 2'b00};
        if (next_bits(1)) r.vaddr[1:0] = 2'(next_bits(2));
        r.wdata = next_bits(32);
        r.is_load = (r.op >= `MEM_OP_LBU);
        r.is_store = !r.is_load;
        r.is_ll = (r.op == `MEM_OP_LW) && (next_bits(2) == 0);
        r.is_sc = (r.op == `MEM_OP_SW) && (next_bits(2) == 0);
        r.prior_exc = (next_bits(4) == 0);
        r.prior_code = 5'(next_bits(5));
        return r;
    endfunction

    function automatic mem_pkg::mem_req_t link_req(input mem_pkg::vaddr_t a, input logic sc);
        mem_pkg::mem_req_t r;
        r = '0;
        r.vaddr = a;
        r.op = sc ? `MEM_OP_SW : `MEM_OP_LW;
        r.wdata = 32'hc0de_0000 | a;
        r.is_load = !sc;
        r.is_store = sc;
        r.is_ll = !sc;
        r.is_sc = sc;
        return r;
    endfunction

    task automatic issue(input mem_pkg::mem_req_t r, input mem_pkg::tlb_result_t t,
                         input logic irq);
        @(negedge clk);
        while (busy) @(negedge clk);
        ack_delay = 2'(next_bits(2));
        @(posedge clk);
        req_valid <= 1'b1;
        req <= r;
        tlb <= t;
        interrupt <= irq;
        config_k0 <= 3'(next_bits(3));
        @(posedge clk);
        req_valid <= 1'b0;
        @(negedge clk);
        while (busy) @(negedge clk);
    endtask

    // Wishbone slave, ack after 0 to 3 wait states
    always @(posedge clk) begin
        if (!rst_n || ack) begin
            ack <= 1'b0;
            wait_cnt <= 2'd0;
        end else if (cyc && wait_cnt == ack_delay) begin
            ack <= 1'b1;
            dat_i <= mem[adr[7:2]];
            for (int b = 0; b < 4; b++) begin
                if (we && sel[b]) mem[adr[7:2]][8*b +: 8] <= dat_o[8*b +: 8];
            end
        end else if (cyc) begin
            wait_cnt <= wait_cnt + 2'd1;
        end
    end

    always @(negedge clk) begin
        if (dut.props.fail_count != 0) begin
            $display("MISMATCH at %0t: assertion in bound checker failed", $time);
            $display("Test failures found");
            $fatal(1, "stopping at first error");
        end
    end

    initial begin
        #((NUM_RAND + 20) * WORST_CYCLES * 40);
        $display("watchdog expired before all requests completed");
        $display("Test failures found");
        $fatal(1, "timeout");
    end

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) mem[i] = (i * 32'h9e37_79b9) ^ (i << 20) ^ 32'h5a5a;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        // linked SC succeeds
        issue(link_req(32'h8000_0040, 1'b0), tlb_clean, 1'b0);
        issue(link_req(32'h8000_0040, 1'b1), tlb_clean, 1'b0);
        // exception in between breaks the link
        issue(link_req(32'h8000_0044, 1'b0), tlb_clean, 1'b0);
        issue(link_req(32'h8000_0048, 1'b0), tlb_clean, 1'b1);
        issue(link_req(32'h8000_0044, 1'b1), tlb_clean, 1'b0);
        // SC to another address
        issue(link_req(32'ha000_0050, 1'b0), tlb_clean, 1'b0);
        issue(link_req(32'ha000_0054, 1'b1), tlb_clean, 1'b0);
        for (int n = 0; n < NUM_RAND; n++) begin
            issue(rand_req(), '{found: next_bits(3) != 0, v: next_bits(3) != 0,
                  d: next_bits(2) != 0, c: 3'(next_bits(3)), pfn: 20'(next_bits(20))},
                  next_bits(4) == 0);
        end
        repeat (4) @(negedge clk);
        if (dut.props.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "checker reported errors");
        end
    end

endmodule
